// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' list.f) include/decode_settings.svh

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) list.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

run: $(BIN)
	./$(BIN) > $(LOG); status=$$?; cat $(LOG); exit $$status

check: run
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// register and pc width
`define DATA_W 32

// register number width and register file depth
`define REG_ADDR_W 5
`define REG_COUNT 32

`endif

// File: list.f
+incdir+include
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/stage_ctrl.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/decode_stage.sv
verification/tb_decode_stage.sv

// File: logic/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_settings.svh"

module branch_unit (
    input  logic                ds_to_es_valid,
    input  pipe_pkg::br_kind_t  br_kind,
    input  isa_pkg::inst_word_t ds_inst,
    input  logic [`DATA_W-1:0]  ds_pc,
    input  logic [`DATA_W-1:0]  rs_value,
    input  logic [`DATA_W-1:0]  rt_value,
    output logic                br_taken,
    output logic [`DATA_W-1:0]  br_target
);

    logic               cond;
    logic [`DATA_W-1:0] slot_pc;
    logic [`DATA_W-1:0] offset;

    // delay slot pc and word offset of the branch
    assign slot_pc = ds_pc + `DATA_W'(4);
    assign offset  = {{(`DATA_W-18){ds_inst.i.imm[15]}}, ds_inst.i.imm, 2'b00};

    always_comb begin
        case (br_kind)
            pipe_pkg::br_eq:  cond = rs_value == rt_value;
            pipe_pkg::br_ne:  cond = rs_value != rt_value;
            pipe_pkg::br_gez: cond = $signed(rs_value) >= 0;
            pipe_pkg::br_gtz: cond = $signed(rs_value) > 0;
            pipe_pkg::br_lez: cond = $signed(rs_value) <= 0;
            pipe_pkg::br_ltz: cond = $signed(rs_value) < 0;
            pipe_pkg::br_jump_imm, pipe_pkg::br_jump_reg: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign br_taken = ds_to_es_valid && cond;

    always_comb begin
        case (br_kind)
            pipe_pkg::br_jump_imm: br_target = {slot_pc[`DATA_W-1 -: 4], ds_inst.j.jidx, 2'b00};
            pipe_pkg::br_jump_reg: br_target = rs_value;
            default:               br_target = slot_pc + offset;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_settings.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    // from fetch
    input  logic                   fs_to_ds_valid,
    input  isa_pkg::inst_word_t    fs_inst,
    input  logic [`DATA_W-1:0]     fs_pc,
    output logic                   ds_allowin,
    // to execute
    input  logic                   es_allowin,
    output logic                   ds_to_es_valid,
    output pipe_pkg::alu_op_t      alu_op,
    output logic                   src1_is_sa,
    output logic                   src1_is_pc,
    output logic                   src2_is_imm,
    output logic                   src2_is_uimm,
    output logic                   src2_is_8,
    output logic                   load_op,
    output logic                   store_op,
    output logic                   gr_we,
    output logic [`REG_ADDR_W-1:0] dest,
    output logic [15:0]            imm,
    output logic [`DATA_W-1:0]     rs_value,
    output logic [`DATA_W-1:0]     rt_value,
    output logic [`DATA_W-1:0]     ds_pc,
    // register file write from write-back
    input  logic                   rf_we,
    input  logic [`REG_ADDR_W-1:0] rf_waddr,
    input  logic [`DATA_W-1:0]     rf_wdata,
    // producers for bypass
    input  logic                   es_we,
    input  logic [`REG_ADDR_W-1:0] es_dest,
    input  logic                   es_fwd_valid,
    input  logic [`DATA_W-1:0]     es_fwd_data,
    input  logic                   ms_we,
    input  logic [`REG_ADDR_W-1:0] ms_dest,
    input  logic                   ms_fwd_valid,
    input  logic [`DATA_W-1:0]     ms_fwd_data,
    input  logic                   ws_we,
    input  logic [`REG_ADDR_W-1:0] ws_dest,
    input  logic                   ws_fwd_valid,
    input  logic [`DATA_W-1:0]     ws_fwd_data,
    // redirect to fetch
    output logic                   br_taken,
    output logic [`DATA_W-1:0]     br_target
);

    isa_pkg::inst_word_t ds_inst;
    pipe_pkg::br_kind_t  br_kind;
    logic                rs_used;
    logic                rt_used;
    logic                rs_blocked;
    logic                rt_blocked;
    logic [`DATA_W-1:0]  rs_rdata;
    logic [`DATA_W-1:0]  rt_rdata;

    stage_ctrl stage_ctrl_i (
        .ds_valid (),
        .*
    );

    inst_decoder inst_decoder_i (.*);

    reg_file reg_file_i (.*);

    operand_bypass operand_bypass_i (.*);

    branch_unit branch_unit_i (.*);

endmodule

`default_nettype wire

// File: logic/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_settings.svh"

module inst_decoder (
    input  isa_pkg::inst_word_t    ds_inst,
    output pipe_pkg::alu_op_t      alu_op,
    output pipe_pkg::br_kind_t     br_kind,
    output logic                   src1_is_sa,
    output logic                   src1_is_pc,
    output logic                   src2_is_imm,
    output logic                   src2_is_uimm,
    output logic                   src2_is_8,
    output logic                   load_op,
    output logic                   store_op,
    output logic                   gr_we,
    output logic [`REG_ADDR_W-1:0] dest,
    output logic [15:0]            imm,
    output logic                   rs_used,
    output logic                   rt_used
);

    logic              rs_zero;
    logic              sa_zero;
    logic              shift_imm;
    logic              r_known;
    logic              r_alu;
    logic              i_known;
    logic              i_alu;
    logic              inst_jr;
    logic              inst_jal;
    pipe_pkg::alu_op_t r_op;
    pipe_pkg::alu_op_t i_op;

    assign rs_zero   = ds_inst.r.rs == '0;
    assign sa_zero   = ds_inst.r.shamt == '0;
    assign shift_imm = ds_inst.r.funct inside {isa_pkg::fn_sll, isa_pkg::fn_srl, isa_pkg::fn_sra};

    always_comb begin
        r_known = 1'b1;
        case (ds_inst.r.funct)
            isa_pkg::fn_addu: r_op = pipe_pkg::alu_add;
            isa_pkg::fn_subu: r_op = pipe_pkg::alu_sub;
            isa_pkg::fn_slt:  r_op = pipe_pkg::alu_slt;
            isa_pkg::fn_sltu: r_op = pipe_pkg::alu_sltu;
            isa_pkg::fn_and:  r_op = pipe_pkg::alu_and;
            isa_pkg::fn_or:   r_op = pipe_pkg::alu_or;
            isa_pkg::fn_xor:  r_op = pipe_pkg::alu_xor;
            isa_pkg::fn_nor:  r_op = pipe_pkg::alu_nor;
            isa_pkg::fn_sll, isa_pkg::fn_sllv: r_op = pipe_pkg::alu_sll;
            isa_pkg::fn_srl, isa_pkg::fn_srlv: r_op = pipe_pkg::alu_srl;
            isa_pkg::fn_sra, isa_pkg::fn_srav: r_op = pipe_pkg::alu_sra;
            default: begin
                r_op    = pipe_pkg::alu_add;
                r_known = 1'b0;
            end
        endcase
    end

    always_comb begin
        i_known = 1'b1;
        case (ds_inst.i.op)
            isa_pkg::op_addiu: i_op = pipe_pkg::alu_add;
            isa_pkg::op_slti:  i_op = pipe_pkg::alu_slt;
            isa_pkg::op_sltiu: i_op = pipe_pkg::alu_sltu;
            isa_pkg::op_andi:  i_op = pipe_pkg::alu_and;
            isa_pkg::op_ori:   i_op = pipe_pkg::alu_or;
            isa_pkg::op_xori:  i_op = pipe_pkg::alu_xor;
            isa_pkg::op_lui:   i_op = pipe_pkg::alu_lui;
            default: begin
                i_op    = pipe_pkg::alu_add;
                i_known = 1'b0;
            end
        endcase
    end

    // immediate shifts need rs clear and other R-type ops need shamt clear
    assign r_alu    = ds_inst.r.op == isa_pkg::op_special && r_known
                      && (shift_imm ? rs_zero : sa_zero);
    assign i_alu    = i_known && (i_op != pipe_pkg::alu_lui || rs_zero);
    assign inst_jr  = ds_inst.r.op == isa_pkg::op_special && ds_inst.r.funct == isa_pkg::fn_jr
                      && sa_zero && ds_inst.r.rt == '0 && ds_inst.r.rd == '0;
    assign inst_jal = ds_inst.j.op == isa_pkg::op_jal;

    always_comb begin
        br_kind = pipe_pkg::br_none;
        case (ds_inst.i.op)
            isa_pkg::op_beq:  br_kind = pipe_pkg::br_eq;
            isa_pkg::op_bne:  br_kind = pipe_pkg::br_ne;
            isa_pkg::op_blez: if (ds_inst.i.rt == '0) br_kind = pipe_pkg::br_lez;
            isa_pkg::op_bgtz: if (ds_inst.i.rt == '0) br_kind = pipe_pkg::br_gtz;
            isa_pkg::op_regimm: begin
                if (ds_inst.i.rt == isa_pkg::ri_bgez) br_kind = pipe_pkg::br_gez;
                if (ds_inst.i.rt == isa_pkg::ri_bltz) br_kind = pipe_pkg::br_ltz;
            end
            isa_pkg::op_j, isa_pkg::op_jal: br_kind = pipe_pkg::br_jump_imm;
            isa_pkg::op_special: if (inst_jr) br_kind = pipe_pkg::br_jump_reg;
            default: br_kind = pipe_pkg::br_none;
        endcase
    end

    assign alu_op       = r_alu ? r_op : (i_alu ? i_op : pipe_pkg::alu_add);
    assign load_op      = ds_inst.i.op == isa_pkg::op_lw;
    assign store_op     = ds_inst.i.op == isa_pkg::op_sw;
    assign src1_is_sa   = r_alu && shift_imm;
    assign src1_is_pc   = inst_jal;
    assign src2_is_uimm = i_alu && (i_op inside {pipe_pkg::alu_and, pipe_pkg::alu_or,
                                                 pipe_pkg::alu_xor});
    assign src2_is_imm  = (i_alu && !src2_is_uimm) || load_op || store_op;
    assign src2_is_8    = inst_jal;
    assign gr_we        = r_alu || i_alu || load_op || inst_jal;
    assign dest         = inst_jal ? `REG_ADDR_W'(31) :
                          (i_alu || load_op) ? ds_inst.i.rt : ds_inst.r.rd;
    assign imm          = ds_inst.i.imm;

    // every conditional branch and jr read rs but j and jal do not
    assign rs_used = (r_alu && !shift_imm) || (i_alu && i_op != pipe_pkg::alu_lui)
                     || load_op || store_op
                     || (br_kind != pipe_pkg::br_none && br_kind != pipe_pkg::br_jump_imm);
    assign rt_used = r_alu || store_op
                     || br_kind == pipe_pkg::br_eq || br_kind == pipe_pkg::br_ne;

endmodule

`default_nettype wire

// File: logic/isa_pkg.sv
`default_nettype none

`include "decode_settings.svh"

package isa_pkg;

    typedef enum logic [5:0] {
        op_special = 6'h00, op_regimm = 6'h01, op_j     = 6'h02,
        op_jal     = 6'h03, op_beq    = 6'h04, op_bne   = 6'h05,
        op_blez    = 6'h06, op_bgtz   = 6'h07, op_addiu = 6'h09,
        op_slti    = 6'h0a, op_sltiu  = 6'h0b, op_andi  = 6'h0c,
        op_ori     = 6'h0d, op_xori   = 6'h0e, op_lui   = 6'h0f,
        op_lw      = 6'h23, op_sw     = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00, fn_srl  = 6'h02, fn_sra  = 6'h03,
        fn_sllv = 6'h04, fn_srlv = 6'h06, fn_srav = 6'h07,
        fn_jr   = 6'h08, fn_addu = 6'h21, fn_subu = 6'h23,
        fn_and  = 6'h24, fn_or   = 6'h25, fn_xor  = 6'h26,
        fn_nor  = 6'h27, fn_slt  = 6'h2a, fn_sltu = 6'h2b
    } funct_t;

    // rt field under op_regimm
    typedef enum logic [4:0] {
        ri_bltz = 5'h00,
        ri_bgez = 5'h01
    } regimm_t;

    typedef struct packed {
        opcode_t                op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        funct_t                 funct;
    } r_fields_t;

    typedef struct packed {
        opcode_t                op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } i_fields_t;

    typedef struct packed {
        opcode_t     op;
        logic [25:0] jidx;
    } j_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } inst_word_t;

endpackage

`default_nettype wire

// File: logic/operand_bypass.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_settings.svh"

module operand_bypass (
    input  isa_pkg::inst_word_t    ds_inst,
    input  logic                   rs_used,
    input  logic                   rt_used,
    input  logic [`DATA_W-1:0]     rs_rdata,
    input  logic [`DATA_W-1:0]     rt_rdata,
    input  logic                   es_we,
    input  logic [`REG_ADDR_W-1:0] es_dest,
    input  logic                   es_fwd_valid,
    input  logic [`DATA_W-1:0]     es_fwd_data,
    input  logic                   ms_we,
    input  logic [`REG_ADDR_W-1:0] ms_dest,
    input  logic                   ms_fwd_valid,
    input  logic [`DATA_W-1:0]     ms_fwd_data,
    input  logic                   ws_we,
    input  logic [`REG_ADDR_W-1:0] ws_dest,
    input  logic                   ws_fwd_valid,
    input  logic [`DATA_W-1:0]     ws_fwd_data,
    output logic [`DATA_W-1:0]     rs_value,
    output logic [`DATA_W-1:0]     rt_value,
    output logic                   rs_blocked,
    output logic                   rt_blocked
);

    // operand 0 is rs, 1 is rt; producers in priority order es, ms, ws
    logic [`REG_ADDR_W-1:0] src [2];
    logic                   used [2];
    logic [`DATA_W-1:0]     rdata [2];
    logic [`DATA_W-1:0]     value [2];
    logic                   blocked [2];
    logic                   p_we [3];
    logic [`REG_ADDR_W-1:0] p_dest [3];
    logic                   p_valid [3];
    logic [`DATA_W-1:0]     p_data [3];

    assign src     = '{ds_inst.r.rs, ds_inst.r.rt};
    assign used    = '{rs_used, rt_used};
    assign rdata   = '{rs_rdata, rt_rdata};
    assign p_we    = '{es_we, ms_we, ws_we};
    assign p_dest  = '{es_dest, ms_dest, ws_dest};
    assign p_valid = '{es_fwd_valid, ms_fwd_valid, ws_fwd_valid};
    assign p_data  = '{es_fwd_data, ms_fwd_data, ws_fwd_data};

    always_comb begin
        logic found;
        for (int i = 0; i < 2; i++) begin
            found      = 1'b0;
            blocked[i] = 1'b0;
            value[i]   = rdata[i];
            // nearest producer wins and register 0 never matches
            for (int j = 0; j < 3; j++) begin
                if (!found && p_we[j] && src[i] != '0 && p_dest[j] == src[i]) begin
                    found      = 1'b1;
                    blocked[i] = used[i] && !p_valid[j];
                    if (p_valid[j]) value[i] = p_data[j];
                end
            end
        end
    end

    assign rs_value   = value[0];
    assign rt_value   = value[1];
    assign rs_blocked = blocked[0];
    assign rt_blocked = blocked[1];

endmodule

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // loads, stores and jal all use alu_add
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or,  alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    // what branch_unit has to resolve for the held word
    typedef enum logic [3:0] {
        br_none,
        br_eq, br_ne,
        br_gez, br_gtz, br_lez, br_ltz,
        br_jump_imm,
        br_jump_reg
    } br_kind_t;

endpackage

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_settings.svh"

module reg_file (
    input  logic                   clk,
    input  isa_pkg::inst_word_t    ds_inst,
    input  logic                   rf_we,
    input  logic [`REG_ADDR_W-1:0] rf_waddr,
    input  logic [`DATA_W-1:0]     rf_wdata,
    output logic [`DATA_W-1:0]     rs_rdata,
    output logic [`DATA_W-1:0]     rt_rdata
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (rf_we && rf_waddr != '0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // register 0 always reads zero
    assign rs_rdata = (ds_inst.r.rs == '0) ? '0 : regs[ds_inst.r.rs];
    assign rt_rdata = (ds_inst.r.rt == '0) ? '0 : regs[ds_inst.r.rt];

endmodule

`default_nettype wire

// File: logic/stage_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_settings.svh"

module stage_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                fs_to_ds_valid,
    input  isa_pkg::inst_word_t fs_inst,
    input  logic [`DATA_W-1:0]  fs_pc,
    input  logic                es_allowin,
    input  logic                rs_blocked,
    input  logic                rt_blocked,
    output logic                ds_allowin,
    output logic                ds_to_es_valid,
    output logic                ds_valid,
    output isa_pkg::inst_word_t ds_inst,
    output logic [`DATA_W-1:0]  ds_pc
);

    logic ready_go;

    // item may move on once operands settle
    assign ready_go       = !rs_blocked && !rt_blocked;
    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    // held item must not change under back-pressure
    assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> $stable(ds_inst) && $stable(ds_pc))
        else $error("stage_ctrl: held item changed while stalled by execute");

endmodule

`default_nettype wire

// File: verification/tb_decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_settings.svh"

module tb_decode_stage;

    localparam int main_cycles = 2000;
    localparam int quiet_cycles = 300;
    localparam int stall_limit = 200;
    localparam int drain_limit = 50;

    // expected view of the stage for one held item
    typedef struct packed {
        logic [3:0]  alu;
        logic        sa1;
        logic        pc1;
        logic        imm2;
        logic        uimm2;
        logic        eight2;
        logic        ld;
        logic        st;
        logic        we;
        logic [4:0]  dest;
        logic [15:0] imm;
        logic [31:0] rsv;
        logic [31:0] rtv;
        logic        rs_ok;
        logic        rt_ok;
        logic        rs_blk;
        logic        rt_blk;
        logic        br_any;
        logic        br_cond;
        logic [31:0] target;
    } expect_t;

    localparam logic [5:0] r_funct_list [14] = '{
        6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25, 6'h26,
        6'h27, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07
    };
    localparam logic [5:0] i_opcode_list [7] = '{
        6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f
    };

    logic                   clk;
    logic                   reset;
    logic                   fs_to_ds_valid;
    isa_pkg::inst_word_t    fs_inst;
    logic [`DATA_W-1:0]     fs_pc;
    logic                   ds_allowin;
    logic                   es_allowin;
    logic                   ds_to_es_valid;
    pipe_pkg::alu_op_t      alu_op;
    logic                   src1_is_sa;
    logic                   src1_is_pc;
    logic                   src2_is_imm;
    logic                   src2_is_uimm;
    logic                   src2_is_8;
    logic                   load_op;
    logic                   store_op;
    logic                   gr_we;
    logic [`REG_ADDR_W-1:0] dest;
    logic [15:0]            imm;
    logic [`DATA_W-1:0]     rs_value;
    logic [`DATA_W-1:0]     rt_value;
    logic [`DATA_W-1:0]     ds_pc;
    logic                   rf_we;
    logic [`REG_ADDR_W-1:0] rf_waddr;
    logic [`DATA_W-1:0]     rf_wdata;
    logic                   es_we;
    logic [`REG_ADDR_W-1:0] es_dest;
    logic                   es_fwd_valid;
    logic [`DATA_W-1:0]     es_fwd_data;
    logic                   ms_we;
    logic [`REG_ADDR_W-1:0] ms_dest;
    logic                   ms_fwd_valid;
    logic [`DATA_W-1:0]     ms_fwd_data;
    logic                   ws_we;
    logic [`REG_ADDR_W-1:0] ws_dest;
    logic                   ws_fwd_valid;
    logic [`DATA_W-1:0]     ws_fwd_data;
    logic                   br_taken;
    logic [`DATA_W-1:0]     br_target;

    logic [31:0] shadow [`REG_COUNT];
    logic [63:0] held [$];
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          reset_edges;
    int          stall_cycles;

    decode_stage decode_stage_i (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng = xorshift(rng);
        v = rng;
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want)
        else begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // returns {defined, blocked, value}, nearest producer first
    function automatic logic [33:0] resolve(input logic [4:0] r, input logic used);
        logic [31:0] v;
        logic        blk;
        logic        ok;
        v = shadow[r];
        blk = 1'b0;
        ok = 1'b1;
        if (r != 0) begin
            if (es_we && es_dest == r) begin
                v = es_fwd_valid ? es_fwd_data : v;
                blk = used && !es_fwd_valid;
                ok = es_fwd_valid;
            end else if (ms_we && ms_dest == r) begin
                v = ms_fwd_valid ? ms_fwd_data : v;
                blk = used && !ms_fwd_valid;
                ok = ms_fwd_valid;
            end else if (ws_we && ws_dest == r) begin
                v = ws_fwd_valid ? ws_fwd_data : v;
                blk = used && !ws_fwd_valid;
                ok = ws_fwd_valid;
            end
        end
        return {ok, blk, v};
    endfunction

    function automatic expect_t reference(input logic [31:0] w, input logic [31:0] pc);
        expect_t     e;
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [5:0]  fn;
        logic        r_alu;
        logic        i_alu;
        logic        shift_imm;
        logic        lui;
        logic        jal;
        int          k;
        logic [33:0] a;
        logic [33:0] b;
        logic [31:0] slot;
        op = w[31:26];
        rs = w[25:21];
        rt = w[20:16];
        fn = w[5:0];
        e = '0;
        e.alu = pipe_pkg::alu_add;
        e.imm = w[15:0];
        r_alu = 1'b0;
        i_alu = 1'b0;
        lui = 1'b0;
        k = 0;
        shift_imm = fn inside {6'h00, 6'h02, 6'h03};
        if (op == 6'h00) begin
            r_alu = shift_imm ? rs == 0 : w[10:6] == 0;
            case (fn)
                6'h21: e.alu = pipe_pkg::alu_add;
                6'h23: e.alu = pipe_pkg::alu_sub;
                6'h2a: e.alu = pipe_pkg::alu_slt;
                6'h2b: e.alu = pipe_pkg::alu_sltu;
                6'h24: e.alu = pipe_pkg::alu_and;
                6'h25: e.alu = pipe_pkg::alu_or;
                6'h26: e.alu = pipe_pkg::alu_xor;
                6'h27: e.alu = pipe_pkg::alu_nor;
                6'h00, 6'h04: e.alu = pipe_pkg::alu_sll;
                6'h02, 6'h06: e.alu = pipe_pkg::alu_srl;
                6'h03, 6'h07: e.alu = pipe_pkg::alu_sra;
                default: r_alu = 1'b0;
            endcase
            if (!r_alu) e.alu = pipe_pkg::alu_add;
            if (fn == 6'h08 && w[20:6] == 0) k = 8;
        end else if (op >= 6'h09 && op <= 6'h0f) begin
            lui = op == 6'h0f;
            i_alu = !lui || rs == 0;
            case (op)
                6'h0a: e.alu = pipe_pkg::alu_slt;
                6'h0b: e.alu = pipe_pkg::alu_sltu;
                6'h0c: e.alu = pipe_pkg::alu_and;
                6'h0d: e.alu = pipe_pkg::alu_or;
                6'h0e: e.alu = pipe_pkg::alu_xor;
                6'h0f: e.alu = i_alu ? pipe_pkg::alu_lui : pipe_pkg::alu_add;
                default: e.alu = pipe_pkg::alu_add;
            endcase
            e.uimm2 = i_alu && op inside {6'h0c, 6'h0d, 6'h0e};
        end
        case (op)
            6'h04: k = 1;
            6'h05: k = 2;
            6'h01: k = (rt == 1) ? 3 : (rt == 0) ? 6 : 0;
            6'h07: k = (rt == 0) ? 4 : 0;
            6'h06: k = (rt == 0) ? 5 : 0;
            6'h02, 6'h03: k = 7;
            default: ;
        endcase
        jal = op == 6'h03;
        e.ld = op == 6'h23;
        e.st = op == 6'h2b;
        e.sa1 = r_alu && shift_imm;
        e.pc1 = jal;
        e.eight2 = jal;
        e.imm2 = (i_alu && !e.uimm2) || e.ld || e.st;
        e.we = r_alu || i_alu || e.ld || jal;
        e.dest = jal ? 5'd31 : (i_alu || e.ld) ? rt : w[15:11];
        a = resolve(rs, (r_alu && !shift_imm) || (i_alu && !lui) || e.ld || e.st
                        || (k >= 1 && k <= 6) || k == 8);
        b = resolve(rt, r_alu || e.st || k == 1 || k == 2);
        {e.rs_ok, e.rs_blk, e.rsv} = a;
        {e.rt_ok, e.rt_blk, e.rtv} = b;
        case (k)
            1: e.br_cond = e.rsv == e.rtv;
            2: e.br_cond = e.rsv != e.rtv;
            3: e.br_cond = !e.rsv[31];
            4: e.br_cond = !e.rsv[31] && e.rsv != 0;
            5: e.br_cond = e.rsv[31] || e.rsv == 0;
            6: e.br_cond = e.rsv[31];
            7, 8: e.br_cond = 1'b1;
            default: e.br_cond = 1'b0;
        endcase
        e.br_any = k != 0;
        slot = pc + 32'd4;
        if (k == 7) e.target = {slot[31:28], w[25:0], 2'b00};
        else if (k == 8) e.target = e.rsv;
        else e.target = slot + {{14{w[15]}}, w[15:0], 2'b00};
        return e;
    endfunction

    task automatic check_cycle();
        expect_t e;
        logic    ready;
        logic    allow;
        if (held.size() == 0) begin
            compare("ds_to_es_valid", ds_to_es_valid, 0);
            compare("br_taken", br_taken, 0);
            compare("ds_allowin", ds_allowin, 1);
            allow = 1'b1;
        end else begin
            e = reference(held[0][63:32], held[0][31:0]);
            ready = !e.rs_blk && !e.rt_blk;
            allow = ready && es_allowin;
            compare("ds_to_es_valid", ds_to_es_valid, ready);
            compare("ds_allowin", ds_allowin, allow);
            compare("br_taken", br_taken, ready && e.br_cond);
            compare("alu_op", alu_op, e.alu);
            compare("src flags", {src1_is_sa, src1_is_pc, src2_is_imm, src2_is_uimm, src2_is_8},
                    {e.sa1, e.pc1, e.imm2, e.uimm2, e.eight2});
            compare("load/store", {load_op, store_op}, {e.ld, e.st});
            compare("gr_we", gr_we, e.we);
            compare("dest", dest, e.dest);
            compare("imm", imm, e.imm);
            compare("ds_pc", ds_pc, held[0][31:0]);
            if (e.rs_ok) compare("rs_value", rs_value, e.rsv);
            if (e.rt_ok) compare("rt_value", rt_value, e.rtv);
            if (ready && e.br_any) compare("br_target", br_target, e.target);
            if (allow) begin
                void'(held.pop_front());
                stall_cycles = 0;
            end else begin
                stall_cycles++;
            end
        end
        if (fs_to_ds_valid && allow) held.push_back({fs_inst, fs_pc});
    endtask

    always @(posedge clk) begin
        if (reset) begin
            // outputs are defined from the second edge in reset
            if (reset_edges > 0) begin
                compare("ds_to_es_valid in reset", ds_to_es_valid, 0);
                compare("br_taken in reset", br_taken, 0);
                compare("ds_allowin in reset", ds_allowin, 1);
            end
            reset_edges++;
        end else begin
            check_cycle();
        end
        if (rf_we && rf_waddr != 0) shadow[rf_waddr] = rf_wdata;
    end

    task automatic make_inst(output logic [31:0] w);
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        int          pick;
        next_rand(r);
        next_rand(s);
        // few registers so hazards happen often
        rs = {2'b00, r[2:0]};
        rt = {2'b00, r[5:3]};
        rd = {2'b00, r[8:6]};
        pick = s[4:0];
        if (pick < 14) begin
            w = {6'h00, rs, rt, rd, r[13:9], r_funct_list[pick]};
            if (pick >= 8 && pick <= 10) w[25:21] = 5'd0;
            else w[10:6] = 5'd0;
        end else if (pick < 21) begin
            w = {i_opcode_list[pick-14], rs, rt, r[31:16]};
            if (pick == 20) w[25:21] = 5'd0;
        end else if (pick == 21) w = {6'h23, rs, rt, r[31:16]};
        else if (pick == 22) w = {6'h2b, rs, rt, r[31:16]};
        else if (pick == 23) w = {6'h04, rs, rt, r[31:16]};
        else if (pick == 24) w = {6'h05, rs, rt, r[31:16]};
        else if (pick == 25) w = {6'h06, rs, 5'd0, r[31:16]};
        else if (pick == 26) w = {6'h07, rs, 5'd0, r[31:16]};
        else if (pick == 27) w = {6'h01, rs, 5'd1, r[31:16]};
        else if (pick == 28) w = {6'h01, rs, 5'd0, r[31:16]};
        else if (pick == 29) w = {s[5] ? 6'h03 : 6'h02, r[25:0]};
        else if (pick == 30) w = {6'h00, rs, 15'd0, 6'h08};
        else w = r;
    endtask

    task automatic drive_producers(input logic quiet);
        logic [31:0] v;
        next_rand(v);
        es_we = !quiet && v[0];
        es_dest = {2'b00, v[3:1]};
        es_fwd_valid = v[5:4] != 0;
        ms_we = !quiet && v[6];
        ms_dest = {2'b00, v[9:7]};
        ms_fwd_valid = v[11:10] != 0;
        ws_we = !quiet && v[12];
        ws_dest = {2'b00, v[15:13]};
        ws_fwd_valid = v[17:16] != 0;
        next_rand(es_fwd_data);
        next_rand(ms_fwd_data);
        next_rand(ws_fwd_data);
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] w;
        logic        timed_out;
        int          n;
        rng = 32'ha23f;
        errors = 0;
        checks = 0;
        reset_edges = 0;
        stall_cycles = 0;
        timed_out = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) shadow[i] = '0;
        clk = 1'b0;
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_inst = '0;
        fs_pc = '0;
        es_allowin = 1'b0;
        rf_we = 1'b0;
        rf_waddr = '0;
        rf_wdata = '0;
        drive_producers(1'b1);
        repeat (10) @(posedge clk);

        // fill every register once so reads are known
        for (int i = 1; i < `REG_COUNT; i++) begin
            @(negedge clk);
            reset = 1'b0;
            rf_we = 1'b1;
            rf_waddr = i[4:0];
            next_rand(rf_wdata);
        end

        n = 0;
        while (n < main_cycles && !timed_out) begin
            @(negedge clk);
            next_rand(v);
            make_inst(w);
            fs_to_ds_valid = v[1:0] != 0;
            fs_inst = w;
            fs_pc = {v[31:10], 10'd0} + {20'd0, n[9:0], 2'b00};
            es_allowin = v[3:2] != 0;
            rf_we = v[4];
            rf_waddr = v[9:5];
            next_rand(rf_wdata);
            drive_producers(n < quiet_cycles);
            if (stall_cycles > stall_limit) timed_out = 1'b1;
            n++;
        end

        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        es_allowin = 1'b1;
        rf_we = 1'b0;
        drive_producers(1'b1);
        n = 0;
        while (held.size() != 0 && n < drain_limit) begin
            @(negedge clk);
            n++;
        end
        if (held.size() != 0) timed_out = 1'b1;

        if (timed_out) $display("timeout: an accepted item never left the decode stage");
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
